//--- all.f
lrelu_cfg_pkg.sv
lrelu_data_pkg.sv
lrelu_coeff_regs.sv
lrelu_scale_stage.sv
lrelu_bias_select.sv
lrelu_requant.sv
lrelu_engine.sv
lrelu_engine_assert.sv
tb_lrelu_engine.sv

//--- tb_lrelu_engine.sv
`timescale 1ns/1ps

module tb_lrelu_engine;

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  localparam int UNITS      = 4;
  localparam int CLK_PERIOD = 4;
  localparam int DRV        = 1;
  localparam int RST_CYCLES = 16;
  localparam int LATENCY    = 3;
  localparam int DRAIN_MAX  = 20;
  // cycle budgets of reset and each test in run order
  localparam int CYCLE_BUDGET = 20 + 70 + 60 + 60 + 70 + 70 + 100;

  typedef data_t [UNITS-1:0] beat_t;
  typedef out_t  [UNITS-1:0] lanes_t;

  logic        clk;
  logic        rst;
  logic        clken;
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        s_valid;
  beat_t       s_data;
  user_u       s_user;
  logic        m_valid;
  lanes_t      m_data;
  user_u       m_user;

  // coefficient copies for the reference model
  coeff_t      sh_a;
  coeff_t      sh_b [N_BIAS];
  coeff_t      sh_d;
  alpha_t      sh_alpha;

  // beats in flight with the oldest first
  lanes_t      exp_data_q [$];
  user_u       exp_user_q [$];
  int          exp_edge_q [$];

  logic [31:0] lfsr_state;
  string       cur_test = "reset";
  int          edge_cnt = 0;
  int          err_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          failed_tests = 0;
  int          test_errs_at_start = 0;

  lrelu_engine #(.UNITS(UNITS)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR in test %s: %s", cur_test, msg);
  endtask

  task automatic compare_out(input string what, input out_t exp, input out_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("MISMATCH %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_user(input string what, input user_u exp, input user_u act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("MISMATCH %s %s: expected %b actual %b", cur_test, what, exp.raw, act.raw);
    end
  endtask

  task automatic compare_coeff(input string what, input coeff_t exp, input coeff_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("MISMATCH %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // expected output of one lane for the current coefficients
  function automatic out_t ref_lane(input data_t x, input int lane, input user_u u);
    int     col;
    int     row;
    longint t;
    longint q;
    if (u.flags.is_1x1 || !(u.flags.is_left_col || u.flags.is_right_col)) begin
      col = int'(B_COL_CENTER);
    end else if (u.flags.is_left_col) begin
      col = int'(B_COL_LEFT);
    end else begin
      col = int'(B_COL_RIGHT);
    end
    row = int'(B_ROW_MID);
    if (!u.flags.is_1x1 && lane == 0 && u.flags.is_top_block) begin
      row = int'(B_ROW_TOP);
    end else if (!u.flags.is_1x1 && lane == UNITS - 1 && u.flags.is_bottom_block) begin
      row = int'(B_ROW_BOTTOM);
    end
    t = longint'(x) * longint'(sh_a) + longint'(sh_b[col * 3 + row]);
    if (t < 0 && u.flags.is_lrelu) begin
      t = (t * longint'(sh_alpha)) >>> FRAC;
    end
    q = (t + longint'(sh_d)) >>> FRAC;
    if (q > 127) begin
      q = 127;
    end else if (q < -128) begin
      q = -128;
    end
    return out_t'(q);
  endfunction

  function automatic beat_t make_beat(input int v0, input int v1, input int v2, input int v3);
    int    v [4];
    beat_t b;
    v = '{v0, v1, v2, v3};
    for (int lane = 0; lane < UNITS; lane++) begin
      b[lane] = data_t'(v[lane % 4]);
    end
    return b;
  endfunction

  function automatic user_u make_user(input bit lrelu, input bit top, input bit bottom,
                                      input bit one, input bit left, input bit right);
    user_u u;
    u.flags.is_lrelu        = lrelu;
    u.flags.is_top_block    = top;
    u.flags.is_bottom_block = bottom;
    u.flags.is_1x1          = one;
    u.flags.is_left_col     = left;
    u.flags.is_right_col    = right;
    return u;
  endfunction

  // setup phase now, access phase one edge later
  task automatic apb_access(input addr_t addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRV;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      report_error($sformatf("pready low in the access phase to address %0d", addr));
    end
    @(posedge clk);
    #DRV;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input logic [31:0] wdata, output logic err);
    logic [31:0] rd_ignored;
    apb_access(addr, 1'b1, wdata, rd_ignored, err);
  endtask

  task automatic apb_read(input addr_t addr, output logic [31:0] rdata, output logic err);
    apb_access(addr, 1'b0, 32'h0, rdata, err);
  endtask

  function automatic logic [31:0] shadow_word(input int addr);
    if (addr == int'(ADDR_A)) begin
      return {16'h0, sh_a};
    end else if (addr == int'(ADDR_D)) begin
      return {16'h0, sh_d};
    end else if (addr == int'(ADDR_ALPHA)) begin
      return {24'h0, sh_alpha};
    end
    return {16'h0, sh_b[addr - int'(ADDR_B_BASE)]};
  endfunction

  // junk above the register width must be dropped
  task automatic write_coeffs();
    logic        err;
    logic [31:0] junk;
    for (int addr = 0; addr <= int'(ADDR_ALPHA); addr++) begin
      junk = (addr == int'(ADDR_ALPHA)) ? 32'ha5a5_5a00 : 32'ha5a5_0000;
      apb_write(addr_t'(addr), shadow_word(addr) | junk, err);
      if (err) begin
        report_error($sformatf("pslverr on write to valid address %0d", addr));
      end
    end
  endtask

  task automatic send_beat(input beat_t data, input user_u user);
    logic taken;
    s_valid = 1'b1;
    s_data  = data;
    s_user  = user;
    do begin
      @(negedge clk);
      taken = clken;
      @(posedge clk);
    end while (!taken);
    #DRV;
    s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_user_q.size() != 0 && cycles < DRAIN_MAX) begin
      @(posedge clk);
      cycles++;
    end
    // idle edges catch a stray extra beat
    repeat (3) @(posedge clk);
    #DRV;
    if (exp_user_q.size() != 0) begin
      report_error($sformatf("%0d beats never reached the output", exp_user_q.size()));
      exp_data_q.delete();
      exp_user_q.delete();
      exp_edge_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs_at_start = err_count;
  endtask

  task automatic end_test();
    int errs;
    errs = err_count - test_errs_at_start;
    test_count++;
    if (errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", cur_test, errs);
    end
  endtask

  task automatic test_regs();
    logic [31:0] rdata;
    logic [31:0] word;
    logic        err;
    start_test("regs");
    sh_a = 16'sh1234;
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = coeff_t'(16'h8001 + i * 16'h0111);
    end
    sh_d     = 16'shfedc;
    sh_alpha = 8'ha5;
    write_coeffs();
    for (int addr = 0; addr <= int'(ADDR_ALPHA); addr++) begin
      word = shadow_word(addr);
      apb_read(addr_t'(addr), rdata, err);
      compare_coeff($sformatf("address %0d", addr), word[15:0], rdata[15:0]);
      if (err || rdata[31:16] != 16'h0) begin
        report_error($sformatf("read of address %0d gave pslverr or upper bits", addr));
      end
    end
    apb_write(6'd20, 32'hffff_ffff, err);
    if (!err) begin
      report_error("write to address 20 gave no pslverr");
    end
    apb_read(6'd20, rdata, err);
    if (!err || rdata[31:16] != 16'h0) begin
      report_error("read of address 20 gave no pslverr or nonzero upper bits");
    end
    compare_coeff("address 20", 16'sh0, rdata[15:0]);
    apb_read(ADDR_A, rdata, err);
    compare_coeff("address 0 after bad write", sh_a, rdata[15:0]);
    end_test();
  endtask

  task automatic test_affine();
    start_test("affine");
    sh_a = 16'sh0100;
    // wrong bias entries would push results far off
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = 16'sh7f00;
    end
    sh_b[0]  = 16'sh0080;
    sh_d     = -16'sh0100;
    sh_alpha = 8'h80;
    write_coeffs();
    send_beat(make_beat(10, -10, 0, 100), make_user(0, 0, 0, 0, 0, 0));
    send_beat(make_beat(1000, -1000, 127, -129), make_user(0, 0, 0, 0, 0, 0));
    send_beat(make_beat(32767, -32768, 128, -128), make_user(0, 0, 0, 0, 0, 0));
    wait_drain();
    end_test();
  endtask

  task automatic test_leaky();
    start_test("leaky");
    sh_a = 16'sh0100;
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = 16'sh0;
    end
    sh_d     = 16'sh0;
    sh_alpha = 8'h40;
    write_coeffs();
    send_beat(make_beat(-100, 100, -4, -1), make_user(1, 0, 0, 0, 0, 0));
    send_beat(make_beat(-100, 100, -4, -1), make_user(0, 0, 0, 0, 0, 0));
    send_beat(make_beat(-1000, -20000, 7, -3), make_user(1, 0, 0, 0, 0, 0));
    send_beat(make_beat(-1000, -20000, 7, -3), make_user(0, 0, 0, 0, 0, 0));
    wait_drain();
    end_test();
  endtask

  task automatic test_bias();
    start_test("bias");
    // A of zero leaves only the chosen bias
    sh_a = 16'sh0;
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = coeff_t'((i * 10 - 40) * 256);
    end
    sh_d     = 16'sh0;
    sh_alpha = 8'h80;
    write_coeffs();
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 0, 0, 0, 0, 0));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 1, 1, 1, 1, 1));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 0, 0, 0, 1, 0));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 0, 0, 0, 0, 1));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 0, 0, 0, 1, 1));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 1, 0, 0, 0, 0));
    send_beat(make_beat(1, 2, 3, 4), make_user(0, 0, 1, 0, 1, 0));
    send_beat(make_beat(1, 2, 3, 4), make_user(1, 1, 1, 0, 0, 1));
    wait_drain();
    end_test();
  endtask

  task automatic test_stall();
    start_test("stall");
    sh_a = 16'sh0100;
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = 16'sh0;
    end
    sh_b[0]  = 16'sh0040;
    sh_d     = 16'sh0080;
    sh_alpha = 8'h80;
    write_coeffs();
    send_beat(make_beat(5, -6, 70, -80), make_user(1, 0, 0, 0, 0, 0));
    send_beat(make_beat(-100, 100, -3, 3), make_user(1, 0, 0, 0, 0, 0));
    // two beats in flight, a third waiting at the input
    clken = 1'b0;
    fork
      send_beat(make_beat(-50, 60, 9, -9), make_user(0, 0, 0, 0, 0, 0));
      begin
        repeat (5) @(posedge clk);
        #DRV;
        clken = 1'b1;
      end
    join
    send_beat(make_beat(200, -200, 1, -1), make_user(1, 0, 0, 0, 0, 0));
    clken = 1'b0;
    repeat (4) @(posedge clk);
    #DRV;
    clken = 1'b1;
    wait_drain();
    end_test();
  endtask

  task automatic test_stream();
    logic [31:0] r;
    beat_t       beat;
    user_u       user;
    start_test("stream");
    sh_a = 16'sh0040;
    for (int i = 0; i < N_BIAS; i++) begin
      r = rand_bits(12);
      sh_b[i] = coeff_t'($signed(r[11:0]));
    end
    r        = rand_bits(12);
    sh_d     = coeff_t'($signed(r[11:0]));
    sh_alpha = alpha_t'(rand_bits(8));
    write_coeffs();
    for (int n = 0; n < 40; n++) begin
      for (int lane = 0; lane < UNITS; lane++) begin
        r = rand_bits(10);
        beat[lane] = data_t'($signed(r[9:0]));
      end
      r        = rand_bits(USER_W);
      user.raw = r[USER_W-1:0];
      send_beat(beat, user);
    end
    wait_drain();
    end_test();
  endtask

  // scoreboard samples at the falling edge where everything is settled
  initial begin : output_monitor
    logic   en_prev;
    logic   stall_prev;
    logic   last_valid;
    lanes_t last_data;
    user_u  last_user;
    lanes_t exp_lanes;
    user_u  exp_user;
    int     entry;
    en_prev    = 1'b0;
    stall_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (en_prev) begin
        edge_cnt++;
        if (m_valid && exp_user_q.size() == 0) begin
          report_error("m_valid high with no beat in flight");
        end else if (m_valid) begin
          exp_lanes = exp_data_q.pop_front();
          exp_user  = exp_user_q.pop_front();
          entry     = exp_edge_q.pop_front();
          // the accepting edge is the first of the three
          if (edge_cnt - entry + 1 != LATENCY) begin
            report_error($sformatf("beat came out after %0d enabled edges instead of %0d",
                                   edge_cnt - entry + 1, LATENCY));
          end
          for (int lane = 0; lane < UNITS; lane++) begin
            compare_out($sformatf("lane %0d", lane), exp_lanes[lane], m_data[lane]);
          end
          compare_user("m_user", exp_user, m_user);
        end
      end else if (stall_prev) begin
        if (m_valid !== last_valid || m_data !== last_data || m_user !== last_user) begin
          report_error("outputs changed on an edge with clken low");
        end
      end
      last_valid = m_valid;
      last_data  = m_data;
      last_user  = m_user;
      if (!rst && clken && s_valid) begin
        for (int lane = 0; lane < UNITS; lane++) begin
          exp_lanes[lane] = ref_lane(s_data[lane], lane, s_user);
        end
        exp_data_q.push_back(exp_lanes);
        exp_user_q.push_back(s_user);
        exp_edge_q.push_back(edge_cnt + 1);
      end
      en_prev    = clken && !rst;
      stall_prev = !clken && !rst;
    end
  end

  initial begin : watchdog
    #(CYCLE_BUDGET * 4 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", CYCLE_BUDGET * 4);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    lfsr_state = 32'he703;
    rst        = 1'b1;
    clken      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    s_valid    = 1'b0;
    s_data     = '0;
    s_user     = '0;
    sh_a       = '0;
    sh_d       = '0;
    sh_alpha   = '0;
    for (int i = 0; i < N_BIAS; i++) begin
      sh_b[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #DRV;
    rst = 1'b0;
    test_regs();
    test_affine();
    test_leaky();
    test_bias();
    test_stall();
    test_stream();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, failed_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- lrelu_engine_assert.sv
`timescale 1ns/1ps

module lrelu_engine_assert (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic m_valid
);

  // no wait states on APB
  a_pready_in_access : assert property (
    @(posedge clk) disable iff (rst) (psel && penable) |-> pready
  ) else $error("pready low in an APB access phase");

  a_pslverr_in_access : assert property (
    @(posedge clk) pslverr |-> (psel && penable)
  ) else $error("pslverr high outside an APB access phase");

  // output stream stays quiet while reset is held
  a_no_valid_in_reset : assert property (
    @(posedge clk) rst |=> !m_valid
  ) else $error("m_valid high during reset");

endmodule

bind lrelu_engine lrelu_engine_assert i_assert (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .m_valid (m_valid)
);

//--- lrelu_engine.sv
`timescale 1ns/1ps

module lrelu_engine #(
  parameter int UNITS = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clken,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  lrelu_cfg_pkg::addr_t                  paddr,
  input  logic [lrelu_cfg_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [lrelu_cfg_pkg::APB_DATA_W-1:0]  prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  input  logic                                  s_valid,
  input  lrelu_data_pkg::data_t [UNITS-1:0]     s_data,
  input  lrelu_data_pkg::user_u                 s_user,
  output logic                                  m_valid,
  output lrelu_data_pkg::out_t [UNITS-1:0]      m_data,
  output lrelu_data_pkg::user_u                 m_user
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  coeff_t                coeff_a;
  coeff_t [N_BIAS-1:0]   coeff_b;
  coeff_t                coeff_d;
  alpha_t                alpha;

  prod_t  [UNITS-1:0]    prod;
  logic                  prod_valid;
  user_u                 prod_user;
  coeff_t [UNITS-1:0]    bias;

  lrelu_coeff_regs i_coeff_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .coeff_a (coeff_a),
    .coeff_b (coeff_b),
    .coeff_d (coeff_d),
    .alpha   (alpha)
  );

  // product and bias are registered on the same edge
  lrelu_scale_stage #(
    .UNITS (UNITS)
  ) i_scale (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .s_user     (s_user),
    .coeff_a    (coeff_a),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_user  (prod_user)
  );

  lrelu_bias_select #(
    .UNITS (UNITS)
  ) i_bias (
    .clk     (clk),
    .rst     (rst),
    .clken   (clken),
    .s_user  (s_user),
    .coeff_b (coeff_b),
    .bias    (bias)
  );

  lrelu_requant #(
    .UNITS (UNITS)
  ) i_requant (
    .clk        (clk),
    .rst        (rst),
    .clken      (clken),
    .prod       (prod),
    .prod_valid (prod_valid),
    .prod_user  (prod_user),
    .bias       (bias),
    .coeff_d    (coeff_d),
    .alpha      (alpha),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_user     (m_user)
  );

endmodule

//--- lrelu_requant.sv
`timescale 1ns/1ps

module lrelu_requant #(
  parameter int UNITS = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                clken,
  input  lrelu_data_pkg::prod_t [UNITS-1:0]   prod,
  input  logic                                prod_valid,
  input  lrelu_data_pkg::user_u               prod_user,
  input  lrelu_cfg_pkg::coeff_t [UNITS-1:0]   bias,
  input  lrelu_cfg_pkg::coeff_t               coeff_d,
  input  lrelu_cfg_pkg::alpha_t               alpha,
  output logic                                m_valid,
  output lrelu_data_pkg::out_t [UNITS-1:0]    m_data,
  output lrelu_data_pkg::user_u               m_user
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  prod_t [UNITS-1:0] t_next;
  prod_t [UNITS-1:0] t_q;
  logic              t_valid;
  user_u             t_user;
  out_t  [UNITS-1:0] q_next;

  // first stage: bias add, then leak on negative results
  always_comb begin
    prod_t                         sum;
    logic signed [PROD_W+ALPHA_W:0] leak;
    for (int lane = 0; lane < UNITS; lane++) begin
      sum  = prod[lane] + bias[lane];
      leak = sum * $signed({1'b0, alpha});
      if (sum[PROD_W-1] && prod_user.flags.is_lrelu) begin
        t_next[lane] = prod_t'(leak >>> FRAC);
      end else begin
        t_next[lane] = sum;
      end
    end
  end

  // second stage: D add, drop fraction, clip to 8 bits
  always_comb begin
    prod_t acc;
    prod_t scaled;
    for (int lane = 0; lane < UNITS; lane++) begin
      acc    = t_q[lane] + coeff_d;
      scaled = acc >>> FRAC;
      if (scaled > OUT_MAX) begin
        q_next[lane] = out_t'(OUT_MAX);
      end else if (scaled < OUT_MIN) begin
        q_next[lane] = out_t'(OUT_MIN);
      end else begin
        q_next[lane] = out_t'(scaled);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      t_q    <= t_next;
      m_data <= q_next;
    end
  end

  // sideband follows the data through both registers
  always_ff @(posedge clk) begin
    if (rst) begin
      t_valid <= 1'b0;
      t_user  <= '0;
      m_valid <= 1'b0;
      m_user  <= '0;
    end else if (clken) begin
      t_valid <= prod_valid;
      t_user  <= prod_user;
      m_valid <= t_valid;
      m_user  <= t_user;
    end
  end

endmodule

//--- lrelu_bias_select.sv
`timescale 1ns/1ps

module lrelu_bias_select #(
  parameter int UNITS = 4
) (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            clken,
  input  lrelu_data_pkg::user_u                           s_user,
  input  lrelu_cfg_pkg::coeff_t [lrelu_cfg_pkg::N_BIAS-1:0] coeff_b,
  output lrelu_cfg_pkg::coeff_t [UNITS-1:0]               bias
);

  import lrelu_cfg_pkg::*;
  import lrelu_data_pkg::*;

  logic [1:0]              col;
  logic [1:0]              row [UNITS];
  coeff_t [UNITS-1:0]      bias_next;

  // column is the same for every lane of the beat
  always_comb begin
    if (s_user.flags.is_1x1) begin
      col = B_COL_CENTER;
    end else if (s_user.flags.is_left_col) begin
      col = B_COL_LEFT;
    end else if (s_user.flags.is_right_col) begin
      col = B_COL_RIGHT;
    end else begin
      col = B_COL_CENTER;
    end
  end

  // only the outer lanes see the top and bottom edges
  always_comb begin
    for (int lane = 0; lane < UNITS; lane++) begin
      row[lane] = B_ROW_MID;
      if (!s_user.flags.is_1x1) begin
        if (lane == 0 && s_user.flags.is_top_block) begin
          row[lane] = B_ROW_TOP;
        end else if (lane == UNITS - 1 && s_user.flags.is_bottom_block) begin
          row[lane] = B_ROW_BOTTOM;
        end
      end
      bias_next[lane] = coeff_b[b_index(col, row[lane])];
    end
  end

  // sampled on the same edge as the scale stage
  always_ff @(posedge clk) begin
    if (rst) begin
      bias <= '0;
    end else if (clken) begin
      bias <= bias_next;
    end
  end

endmodule

//--- lrelu_scale_stage.sv
`timescale 1ns/1ps

module lrelu_scale_stage #(
  parameter int UNITS = 4
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   clken,
  input  logic                                   s_valid,
  input  lrelu_data_pkg::data_t [UNITS-1:0]      s_data,
  input  lrelu_data_pkg::user_u                  s_user,
  input  lrelu_cfg_pkg::coeff_t                  coeff_a,
  output lrelu_data_pkg::prod_t [UNITS-1:0]      prod,
  output logic                                   prod_valid,
  output lrelu_data_pkg::user_u                  prod_user
);

  import lrelu_data_pkg::*;

  prod_t [UNITS-1:0] prod_next;

  // x times A, result keeps the 8 fraction bits of A
  always_comb begin
    for (int lane = 0; lane < UNITS; lane++) begin
      prod_next[lane] = $signed(s_data[lane]) * $signed(coeff_a);
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      prod <= prod_next;
    end
  end

  // valid and user travel with the product
  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      prod_user  <= '0;
    end else if (clken) begin
      prod_valid <= s_valid;
      prod_user  <= s_user;
    end
  end

endmodule

//--- lrelu_coeff_regs.sv
`timescale 1ns/1ps

module lrelu_coeff_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  lrelu_cfg_pkg::addr_t                  paddr,
  input  logic [lrelu_cfg_pkg::APB_DATA_W-1:0]  pwdata,
  output logic [lrelu_cfg_pkg::APB_DATA_W-1:0]  prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output lrelu_cfg_pkg::coeff_t                 coeff_a,
  output lrelu_cfg_pkg::coeff_t [lrelu_cfg_pkg::N_BIAS-1:0] coeff_b,
  output lrelu_cfg_pkg::coeff_t                 coeff_d,
  output lrelu_cfg_pkg::alpha_t                 alpha
);

  import lrelu_cfg_pkg::*;

  localparam int B_IDX_W = $clog2(N_BIAS);

  logic               access;
  logic               addr_ok;
  logic               hit_b;
  logic [B_IDX_W-1:0] b_sel;

  // access phase of a transfer
  assign access  = psel && penable;
  assign addr_ok = (paddr <= ADDR_LAST);
  assign hit_b   = (paddr >= ADDR_B_BASE) && (paddr < ADDR_B_BASE + N_BIAS);
  assign b_sel   = B_IDX_W'(paddr - ADDR_B_BASE);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access && !addr_ok;

  // writes land on the access edge
  always_ff @(posedge clk) begin
    if (rst) begin
      coeff_a <= '0;
      coeff_b <= '0;
      coeff_d <= '0;
      alpha   <= '0;
    end else if (access && pwrite) begin
      if (paddr == ADDR_A) begin
        coeff_a <= pwdata[COEFF_W-1:0];
      end else if (paddr == ADDR_D) begin
        coeff_d <= pwdata[COEFF_W-1:0];
      end else if (paddr == ADDR_ALPHA) begin
        alpha <= pwdata[ALPHA_W-1:0];
      end else if (hit_b) begin
        coeff_b[b_sel] <= pwdata[COEFF_W-1:0];
      end
    end
  end

  // readback, zero extended
  always_comb begin
    prdata = '0;
    if (psel && !pwrite && addr_ok) begin
      case (paddr)
        ADDR_A: begin
          prdata = {{(APB_DATA_W-COEFF_W){1'b0}}, coeff_a};
        end
        ADDR_D: begin
          prdata = {{(APB_DATA_W-COEFF_W){1'b0}}, coeff_d};
        end
        ADDR_ALPHA: begin
          prdata = {{(APB_DATA_W-ALPHA_W){1'b0}}, alpha};
        end
        default: begin
          // whatever remains in range is the bias bank
          if (hit_b) begin
            prdata = {{(APB_DATA_W-COEFF_W){1'b0}}, coeff_b[b_sel]};
          end
        end
      endcase
    end
  end

endmodule

//--- lrelu_data_pkg.sv
package lrelu_data_pkg;

  // input lane word, signed integer
  localparam int DATA_W = 16;
  // output lane word after requantization
  localparam int OUT_W  = 8;
  // product and accumulator width
  localparam int PROD_W = 32;
  // fraction bits dropped at requantization
  localparam int FRAC   = 8;

  localparam int USER_W = 6;

  // saturation bounds of the output word
  localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
  localparam int OUT_MIN = -(2 ** (OUT_W - 1));

  typedef logic signed [DATA_W-1:0] data_t;
  typedef logic signed [OUT_W-1:0]  out_t;
  typedef logic signed [PROD_W-1:0] prod_t;

  // user sideband, seen either as a raw vector or as position flags
  // is_lrelu sits in bit 0, is_right_col in bit 5
  typedef union packed {
    logic [USER_W-1:0] raw;
    struct packed {
      logic is_right_col;
      logic is_left_col;
      logic is_1x1;
      logic is_bottom_block;
      logic is_top_block;
      logic is_lrelu;
    } flags;
  } user_u;

endpackage

//--- lrelu_cfg_pkg.sv
package lrelu_cfg_pkg;

  // coefficient words, Q8.8 signed
  localparam int COEFF_W = 16;
  // leak factor, unsigned 0.8
  localparam int ALPHA_W = 8;

  localparam int APB_DATA_W = 32;
  localparam int ADDR_W     = 6;

  typedef logic signed [COEFF_W-1:0] coeff_t;
  typedef logic        [ALPHA_W-1:0] alpha_t;
  typedef logic        [ADDR_W-1:0]  addr_t;

  // edge bias bank, 3 columns by 3 rows
  localparam int N_BIAS = 9;

  // register map, word addresses
  localparam addr_t ADDR_A      = 6'd0;
  localparam addr_t ADDR_B_BASE = 6'd1;
  localparam addr_t ADDR_D      = 6'd10;
  localparam addr_t ADDR_ALPHA  = 6'd11;
  localparam addr_t ADDR_LAST   = ADDR_ALPHA;

  // column index of the bias bank
  localparam logic [1:0] B_COL_CENTER = 2'd0;
  localparam logic [1:0] B_COL_LEFT   = 2'd1;
  localparam logic [1:0] B_COL_RIGHT  = 2'd2;

  // row index of the bias bank
  localparam logic [1:0] B_ROW_MID    = 2'd0;
  localparam logic [1:0] B_ROW_TOP    = 2'd1;
  localparam logic [1:0] B_ROW_BOTTOM = 2'd2;

  // position of one bias inside the bank
  function automatic int unsigned b_index(input logic [1:0] col, input logic [1:0] row);
    return col * 3 + row;
  endfunction

endpackage
